// ==== hdl/sample_in_ball_ctrl.sv ====
// SampleInBall controller
// FSM, sign buffer, rejection value counter, per-byte rejection
// and first-valid byte search with sampler mask
`timescale 1ns/100ps
`include "sib_cfg.svh"

module sample_in_ball_ctrl (
  input  logic                 clk,
  input  logic                 rst_b,
  input  logic                 zeroize_i,
  input  logic                 data_valid_i,
  input  sib_pkg::sib_beat_t   data_i,
  output logic                 data_hold_o,
  output logic                 sib_done_o,
  output logic                 swap_valid_o,
  input  logic                 swap_hold_i,
  output sib_pkg::sib_sample_t index_i_o,
  output sib_pkg::sib_sample_t index_j_o,
  output logic                 sign_o
);

  localparam int BEAT_W = $bits(sib_pkg::sib_beat_t);
  localparam int IDX_W  = $clog2(`SIB_NUM_SAMPLERS);
  localparam sib_pkg::sib_sample_t REJ_INIT =
    sib_pkg::sib_sample_t'(`SIB_NUM_COEFF - `SIB_TAU);
  localparam sib_pkg::sib_sample_t REJ_LAST =
    sib_pkg::sib_sample_t'(`SIB_NUM_COEFF - 1);

  sib_pkg::sib_fsm_state_e      state_q;
  sib_pkg::sib_fsm_state_e      state_d;
  sib_pkg::sib_sign_buf_t       sign_buf_q;
  sib_pkg::sib_sample_t         rej_value_q;
  logic [`SIB_NUM_SAMPLERS-1:0] mask_q;
  logic [`SIB_NUM_SAMPLERS-1:0] mask_d;
  logic [`SIB_NUM_SAMPLERS-1:0] sampler_valid;
  logic [IDX_W-1:0]             valid_index;
  logic                         index_found;
  logic                         sampler_hold;
  logic                         swap_accept;
  logic                         last_sample;
  logic                         beat_taken;
  logic                         sign_load_lo;
  logic                         sign_load_hi;

  // Byte passes when unmasked and not above i
  always_comb begin
    for (int k = 0; k < `SIB_NUM_SAMPLERS; k++) begin
      sampler_valid[k] = mask_q[k] &&
                         (data_i[k*`SIB_SAMPLE_W +: `SIB_SAMPLE_W] <= rej_value_q);
    end
  end

  // First passing byte, mask off everything up to it
  always_comb begin
    index_found = 1'b0;
    valid_index = '0;
    mask_d      = mask_q;
    for (int k = 0; k < `SIB_NUM_SAMPLERS; k++) begin
      if (data_valid_i && !index_found) begin
        mask_d[k] = 1'b0;
        if (sampler_valid[k]) begin
          index_found = 1'b1;
          valid_index = IDX_W'(k);
        end
      end
    end
  end

  assign swap_valid_o = (state_q == sib_pkg::SIB_ACTIVE) && index_found;
  assign swap_accept  = swap_valid_o && !swap_hold_i;
  // More bytes of this beat still to examine
  assign sampler_hold = index_found && (valid_index != IDX_W'(`SIB_NUM_SAMPLERS - 1));
  assign last_sample  = swap_accept && (rej_value_q == REJ_LAST);

  assign index_i_o = rej_value_q;
  assign index_j_o = data_i[valid_index*`SIB_SAMPLE_W +: `SIB_SAMPLE_W];
  assign sign_o    = sign_buf_q[0];

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      sib_pkg::SIB_IDLE: begin
        if (data_valid_i) state_d = sib_pkg::SIB_SIGN_BUFFER;
      end
      sib_pkg::SIB_SIGN_BUFFER: begin
        if (data_valid_i) state_d = sib_pkg::SIB_ACTIVE;
      end
      sib_pkg::SIB_ACTIVE: begin
        if (last_sample) state_d = sib_pkg::SIB_DONE;
      end
      sib_pkg::SIB_DONE: begin
        // Wait out the final write
        if (!swap_hold_i) state_d = sib_pkg::SIB_IDLE;
      end
      default: begin
        state_d = sib_pkg::SIB_IDLE;
      end
    endcase
  end

  // Stream handshake and done pulse
  always_comb begin
    data_hold_o = 1'b0;
    sib_done_o  = 1'b0;
    unique case (state_q)
      sib_pkg::SIB_IDLE: begin
        data_hold_o = 1'b0;
      end
      sib_pkg::SIB_SIGN_BUFFER: begin
        data_hold_o = 1'b0;
      end
      sib_pkg::SIB_ACTIVE: begin
        // Last swap releases the beat even with bytes left
        data_hold_o = data_valid_i && (swap_hold_i || (sampler_hold && !last_sample));
      end
      sib_pkg::SIB_DONE: begin
        data_hold_o = data_valid_i;
        sib_done_o  = !swap_hold_i;
      end
      default: begin
        data_hold_o = data_valid_i;
      end
    endcase
  end

  assign beat_taken   = (state_q == sib_pkg::SIB_ACTIVE) && data_valid_i && !data_hold_o;
  assign sign_load_lo = (state_q == sib_pkg::SIB_IDLE) && data_valid_i;
  assign sign_load_hi = (state_q == sib_pkg::SIB_SIGN_BUFFER) && data_valid_i;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= sib_pkg::SIB_IDLE;
    end else if (zeroize_i) begin
      state_q <= sib_pkg::SIB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Beat 0 fills bits 31..0, beat 1 fills 59..32
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_buf_q <= '0;
    end else if (zeroize_i || sib_done_o) begin
      sign_buf_q <= '0;
    end else if (sign_load_lo) begin
      sign_buf_q <= sib_pkg::sib_sign_buf_t'(data_i);
    end else if (sign_load_hi) begin
      sign_buf_q <= {data_i[`SIB_TAU-BEAT_W-1:0], sign_buf_q[BEAT_W-1:0]};
    end else if (swap_accept) begin
      sign_buf_q <= sign_buf_q >> 1;
    end
  end

  // Position i, 196 up to 255
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rej_value_q <= REJ_INIT;
    end else if (zeroize_i || sib_done_o) begin
      rej_value_q <= REJ_INIT;
    end else if (swap_accept) begin
      rej_value_q <= rej_value_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mask_q <= '1;
    end else if (zeroize_i || beat_taken) begin
      mask_q <= '1;
    end else if (swap_accept) begin
      mask_q <= mask_d;
    end
  end

endmodule

// ==== hdl/sample_in_ball_shuffler.sv ====
// SampleInBall shuffler
// Two-phase read-modify-write for one Fisher-Yates swap:
// c[i] takes the old c[j], then c[j] becomes +1 or -1
`timescale 1ns/100ps
`include "sib_cfg.svh"

module sample_in_ball_shuffler (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  logic                       valid_i,
  output logic                       hold_o,
  input  sib_pkg::sib_sample_t       index_i_i,
  input  sib_pkg::sib_sample_t       index_j_i,
  input  logic                       sign_i,
  output sib_mem_pkg::sib_mem_req_t  mem_a_o,
  output sib_mem_pkg::sib_mem_req_t  mem_b_o,
  input  sib_mem_pkg::sib_mem_word_t rd_a_i,
  input  sib_mem_pkg::sib_mem_word_t rd_b_i
);

  localparam int OFF_W = $clog2(`SIB_COEFF_PER_WORD);
  localparam int CW    = `SIB_COEFF_W;

  logic                       accept;
  logic                       wr_phase_q;
  sib_pkg::sib_sample_t       idx_i_q;
  sib_pkg::sib_sample_t       idx_j_q;
  logic                       sign_q;
  logic [OFF_W-1:0]           off_i;
  logic [OFF_W-1:0]           off_j;
  logic                       same_word;
  sib_mem_pkg::sib_coeff_t    old_cj;
  sib_mem_pkg::sib_coeff_t    new_cj;
  sib_mem_pkg::sib_mem_word_t word_a;
  sib_mem_pkg::sib_mem_word_t word_b;

  function automatic sib_mem_pkg::sib_mem_addr_t word_addr(input sib_pkg::sib_sample_t idx);
    return sib_mem_pkg::sib_mem_addr_t'(idx >> OFF_W);
  endfunction

  // Busy on the write cycle only
  assign hold_o = wr_phase_q;
  assign accept = valid_i && !wr_phase_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_phase_q <= 1'b0;
    end else if (zeroize_i) begin
      wr_phase_q <= 1'b0;
    end else begin
      wr_phase_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      idx_i_q <= index_i_i;
      idx_j_q <= index_j_i;
      sign_q  <= sign_i;
    end
  end

  // Build the new words from the read data
  always_comb begin
    off_i     = idx_i_q[OFF_W-1:0];
    off_j     = idx_j_q[OFF_W-1:0];
    same_word = (word_addr(idx_i_q) == word_addr(idx_j_q));
    // Sign 0 gives +1 (01), sign 1 gives -1 (11)
    new_cj    = {sign_q, 1'b1};
    old_cj    = rd_b_i[off_j*CW +: CW];

    word_a = rd_a_i;
    word_a[off_i*CW +: CW] = old_cj;
    word_b = rd_b_i;
    word_b[off_j*CW +: CW] = new_cj;

    // Both in one word, c[j] update applied last so it wins for j == i
    if (same_word) begin
      word_a[off_j*CW +: CW] = new_cj;
    end
  end

  // Read on accept, write one cycle later
  always_comb begin
    mem_a_o = '0;
    mem_b_o = '0;
    if (wr_phase_q) begin
      mem_a_o.cs     = 1'b1;
      mem_a_o.we     = 1'b1;
      mem_a_o.addr   = word_addr(idx_i_q);
      mem_a_o.wrdata = word_a;
      mem_b_o.cs     = !same_word;
      mem_b_o.we     = !same_word;
      mem_b_o.addr   = word_addr(idx_j_q);
      mem_b_o.wrdata = word_b;
    end else if (accept) begin
      mem_a_o.cs   = 1'b1;
      mem_a_o.addr = word_addr(index_i_i);
      mem_b_o.cs   = 1'b1;
      mem_b_o.addr = word_addr(index_j_i);
    end
  end

endmodule

// ==== hdl/sib_cfg.svh ====
// Configuration constants for the SampleInBall stage
// Stream geometry, ML-DSA parameter set and coefficient memory layout
`ifndef SIB_CFG_SVH
`define SIB_CFG_SVH

// Input stream, four hash bytes per beat
`define SIB_SAMPLE_W       8
`define SIB_NUM_SAMPLERS   4

// ML-DSA-87 challenge weight and polynomial size
`define SIB_TAU            60
`define SIB_NUM_COEFF      256

// Coefficient storage
`define SIB_COEFF_W        2
`define SIB_COEFF_PER_WORD 4
// 256 coefficients / 4 per word = 64 words
`define SIB_MEM_ADDR_W     6

`endif

// ==== hdl/sib_coeff_mem.sv ====
// Coefficient memory for the SampleInBall polynomial
// 64 x 8 register array, two read/write ports plus a readback port
`timescale 1ns/100ps
`include "sib_cfg.svh"

module sib_coeff_mem (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  sib_mem_pkg::sib_mem_req_t  port_a_i,
  input  sib_mem_pkg::sib_mem_req_t  port_b_i,
  output sib_mem_pkg::sib_mem_word_t rd_a_o,
  output sib_mem_pkg::sib_mem_word_t rd_b_o,
  input  sib_mem_pkg::sib_mem_addr_t rd_addr_i,
  output sib_mem_pkg::sib_mem_word_t rd_data_o
);

  localparam int DEPTH = 1 << `SIB_MEM_ADDR_W;

  sib_mem_pkg::sib_mem_word_t mem_q [DEPTH];

  // All-zero polynomial after reset or zeroize
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem_q[w] <= '0;
      end
    end else if (zeroize_i) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      if (port_a_i.cs && port_a_i.we) begin
        mem_q[port_a_i.addr] <= port_a_i.wrdata;
      end
      if (port_b_i.cs && port_b_i.we) begin
        mem_q[port_b_i.addr] <= port_b_i.wrdata;
      end
    end
  end

  // Registered reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (port_a_i.cs && !port_a_i.we) begin
      rd_a_o <= mem_q[port_a_i.addr];
    end
    if (port_b_i.cs && !port_b_i.we) begin
      rd_b_o <= mem_q[port_b_i.addr];
    end
    rd_data_o <= mem_q[rd_addr_i];
  end

endmodule

// ==== hdl/sib_mem_pkg.sv ====
// Types for the SampleInBall coefficient memory
// Coefficient, memory word, word address and port request
`include "sib_cfg.svh"

package sib_mem_pkg;

  // Two's complement: 00 = 0, 01 = +1, 11 = -1
  typedef logic [`SIB_COEFF_W-1:0] sib_coeff_t;

  // Coefficient k sits at bits 2k+1..2k
  typedef logic [`SIB_COEFF_PER_WORD*`SIB_COEFF_W-1:0] sib_mem_word_t;

  // Coefficient index >> 2
  typedef logic [`SIB_MEM_ADDR_W-1:0] sib_mem_addr_t;

  // One memory port request
  typedef struct packed {
    logic          cs;
    logic          we;
    sib_mem_addr_t addr;
    sib_mem_word_t wrdata;
  } sib_mem_req_t;

endpackage

// ==== hdl/sib_pkg.sv ====
// Types for the SampleInBall sampling datapath
// Controller FSM states, stream beat, sample byte and sign buffer
`include "sib_cfg.svh"

package sib_pkg;

  // Controller FSM
  typedef enum logic [1:0] {
    SIB_IDLE        = 2'b00,
    SIB_SIGN_BUFFER = 2'b01,
    SIB_ACTIVE      = 2'b10,
    SIB_DONE        = 2'b11
  } sib_fsm_state_e;

  // One hash byte
  // Used as candidate index j and as the rejection value i
  typedef logic [`SIB_SAMPLE_W-1:0] sib_sample_t;

  // One stream beat, byte 0 in the low bits
  typedef logic [`SIB_NUM_SAMPLERS*`SIB_SAMPLE_W-1:0] sib_beat_t;

  // Sign bits, consumed from bit 0 upward
  typedef logic [`SIB_TAU-1:0] sib_sign_buf_t;

endpackage

// ==== hdl/sib_top.sv ====
// SampleInBall top level
// Controller, shuffler and coefficient memory
`timescale 1ns/100ps

module sib_top (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  logic                       data_valid_i,
  input  sib_pkg::sib_beat_t         data_i,
  output logic                       data_hold_o,
  output logic                       sib_done_o,
  input  sib_mem_pkg::sib_mem_addr_t rd_addr_i,
  output sib_mem_pkg::sib_mem_word_t rd_data_o
);

  logic                       swap_valid;
  logic                       swap_hold;
  sib_pkg::sib_sample_t       index_i;
  sib_pkg::sib_sample_t       index_j;
  logic                       sign;
  sib_mem_pkg::sib_mem_req_t  mem_a;
  sib_mem_pkg::sib_mem_req_t  mem_b;
  sib_mem_pkg::sib_mem_word_t rd_a;
  sib_mem_pkg::sib_mem_word_t rd_b;

  sample_in_ball_ctrl i_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .data_hold_o  (data_hold_o),
    .sib_done_o   (sib_done_o),
    .swap_valid_o (swap_valid),
    .swap_hold_i  (swap_hold),
    .index_i_o    (index_i),
    .index_j_o    (index_j),
    .sign_o       (sign)
  );

  sample_in_ball_shuffler i_shuffler (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .valid_i   (swap_valid),
    .hold_o    (swap_hold),
    .index_i_i (index_i),
    .index_j_i (index_j),
    .sign_i    (sign),
    .mem_a_o   (mem_a),
    .mem_b_o   (mem_b),
    .rd_a_i    (rd_a),
    .rd_b_i    (rd_b)
  );

  sib_coeff_mem i_coeff_mem (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .port_a_i  (mem_a),
    .port_b_i  (mem_b),
    .rd_a_o    (rd_a),
    .rd_b_o    (rd_b),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

// ==== sources.f ====
+incdir+hdl
+incdir+verification
hdl/sib_pkg.sv
hdl/sib_mem_pkg.sv
hdl/sample_in_ball_ctrl.sv
hdl/sample_in_ball_shuffler.sv
hdl/sib_coeff_mem.sv
hdl/sib_top.sv
verification/sib_tb.sv

// ==== verification/sib_ref.svh ====
// Reference SampleInBall model for the testbench
// FIPS 204 rule on a byte stream and 2-bit coefficient encoding
`ifndef SIB_REF_SVH
`define SIB_REF_SVH

// 0 gives 00, +1 gives 01, -1 gives 11
function automatic logic [1:0] coeff_code(input int value);
  if (value > 0) begin
    return 2'b01;
  end
  if (value < 0) begin
    return 2'b11;
  end
  return 2'b00;
endfunction

// Signs LSB-first from the first eight bytes, candidates after them
// picked marks every index chosen as j
function automatic void sample_in_ball_model(
  input  logic [7:0]                 bytes [$],
  output sib_mem_pkg::sib_mem_word_t words [`SIB_NUM_COEFF/`SIB_COEFF_PER_WORD],
  output logic [`SIB_NUM_COEFF-1:0]  picked
);
  int          coeff [`SIB_NUM_COEFF];
  logic [63:0] signs;
  int          pos;
  int          j;
  for (int k = 0; k < `SIB_NUM_COEFF; k++) begin
    coeff[k] = 0;
  end
  signs  = '0;
  picked = '0;
  for (int k = 0; k < 8; k++) begin
    signs[8*k +: 8] = bytes[k];
  end
  pos = 8;
  for (int i = `SIB_NUM_COEFF - `SIB_TAU; i < `SIB_NUM_COEFF; i++) begin
    // Skip candidates above i
    do begin
      j = bytes[pos];
      pos++;
    end while (j > i && pos < bytes.size());
    coeff[i]  = coeff[j];
    coeff[j]  = signs[0] ? -1 : 1;
    picked[j] = 1'b1;
    signs     = signs >> 1;
  end
  for (int w = 0; w < `SIB_NUM_COEFF / `SIB_COEFF_PER_WORD; w++) begin
    for (int k = 0; k < `SIB_COEFF_PER_WORD; k++) begin
      words[w][`SIB_COEFF_W*k +: `SIB_COEFF_W] = coeff_code(coeff[`SIB_COEFF_PER_WORD*w + k]);
    end
  end
endfunction

`endif

// ==== verification/sib_tb.sv ====
// Testbench for the SampleInBall top level
// LFSR byte streams, stream driver, readback, comparison process and timeout
`timescale 1ns/100ps
`include "sib_cfg.svh"

module sib_tb;

  localparam int NUM_WORDS       = `SIB_NUM_COEFF / `SIB_COEFF_PER_WORD;
  localparam int NUM_TESTS       = 11;
  // About 102 beats, 60 two-cycle swaps, gaps and 65 readback cycles
  localparam int CYCLES_PER_TEST = 2000;
  localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;

  logic                       clk;
  logic                       rst_b;
  logic                       zeroize_i;
  logic                       data_valid_i;
  sib_pkg::sib_beat_t         data_i;
  logic                       data_hold_o;
  logic                       sib_done_o;
  sib_mem_pkg::sib_mem_addr_t rd_addr_i;
  sib_mem_pkg::sib_mem_word_t rd_data_o;

  logic [31:0]                lfsr_q;
  logic [7:0]                 stream_q [$];
  logic [7:0]                 alt_q [$];
  sib_mem_pkg::sib_mem_word_t exp_words [NUM_WORDS];
  sib_mem_pkg::sib_mem_word_t got_words [NUM_WORDS];
  logic [`SIB_NUM_COEFF-1:0]  picked;
  string                      test_name;
  logic                       check_weight;
  logic                       check_req;
  logic                       check_ack;
  int                         cycles = 0;
  int                         tests_run = 0;
  int                         tests_failed = 0;
  int                         errors = 0;
  int                         done_errors = 0;

  `include "sib_ref.svh"

  sib_top i_sib_top (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .data_hold_o  (data_hold_o),
    .sib_done_o   (sib_done_o),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: no final result after %0d clock cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int k = 0; k < 8; k++) begin
      b[k] = lfsr_bit();
    end
    return b;
  endfunction

  // 8 sign bytes and 400 candidates
  task automatic make_random_stream();
    stream_q.delete();
    for (int k = 0; k < 408; k++) begin
      stream_q.push_back(rand_byte());
    end
  endtask

  // Three 255s before every pick below 255, alt_q keeps only the picks
  task automatic make_rejection_stream();
    logic [7:0] b;
    stream_q.delete();
    alt_q.delete();
    for (int k = 0; k < 8; k++) begin
      b = rand_byte();
      stream_q.push_back(b);
      alt_q.push_back(b);
    end
    for (int i = 196; i < 255; i++) begin
      repeat (3) stream_q.push_back(8'hff);
      b = 8'(rand_byte() % (i + 1));
      stream_q.push_back(b);
      alt_q.push_back(b);
    end
    stream_q.push_back(8'hff);
    alt_q.push_back(8'hff);
    while (stream_q.size() % 4 != 0) begin
      stream_q.push_back(8'h00);
    end
  endtask

  // j equal to i, a repeated j, and j in the same word as i
  task automatic make_collision_stream();
    stream_q.delete();
    for (int k = 0; k < 8; k++) begin
      stream_q.push_back(rand_byte());
    end
    for (int i = 196; i < 256; i++) begin
      case (i % 3)
        0:       stream_q.push_back(8'(i));
        1:       stream_q.push_back(8'd7);
        default: stream_q.push_back(8'(i - 1));
      endcase
    end
  endtask

  task automatic pulse_zeroize();
    @(negedge clk);
    data_valid_i = 1'b0;
    zeroize_i    = 1'b1;
    @(negedge clk);
    zeroize_i = 1'b0;
  endtask

  // Beats until done, or until stop_beat beats were taken
  task automatic send_stream(input int stop_beat, input logic gaps);
    int   idx;
    logic held;
    logic done_seen;
    idx       = 0;
    held      = 1'b0;
    done_seen = 1'b0;
    while (!done_seen && idx < stop_beat) begin
      @(negedge clk);
      if (sib_done_o) begin
        done_seen    = 1'b1;
        data_valid_i = 1'b0;
      end else if (idx < stream_q.size() / 4 && (held || !gaps || lfsr_bit() || lfsr_bit())) begin
        data_valid_i = 1'b1;
        data_i = {stream_q[4*idx+3], stream_q[4*idx+2], stream_q[4*idx+1], stream_q[4*idx]};
        // Hold has settled well before the rising edge
        #1;
        held = data_hold_o;
        if (!held) begin
          idx++;
        end
      end else begin
        data_valid_i = 1'b0;
      end
    end
    // Done is a single-cycle pulse
    if (done_seen) begin
      @(negedge clk);
      if (sib_done_o) begin
        $display("Fail at %0t: done stayed high for more than one cycle", $time);
        done_errors++;
      end
    end
  endtask

  // Read data arrives one cycle after the address
  task automatic read_back();
    for (int w = 0; w <= NUM_WORDS; w++) begin
      @(negedge clk);
      if (w > 0) begin
        got_words[w-1] = rd_data_o;
      end
      if (w < NUM_WORDS) begin
        rd_addr_i = sib_mem_pkg::sib_mem_addr_t'(w);
      end
    end
  endtask

  task automatic request_check(input string name, input logic weight);
    test_name    = name;
    check_weight = weight;
    check_req    = 1'b1;
    wait (check_ack);
    check_req = 1'b0;
    check_ack = 1'b0;
  endtask

  task automatic run_test(input string name, input logic clear_first, input logic gaps);
    if (clear_first) begin
      pulse_zeroize();
    end
    send_stream(1 << 30, gaps);
    read_back();
    request_check(name, 1'b1);
  endtask

  // Readback against the expected polynomial
  initial begin
    int         fails;
    int         nonzero;
    int         idx;
    logic [1:0] code;
    forever begin
      @(posedge check_req);
      fails       = done_errors;
      done_errors = 0;
      nonzero     = 0;
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (got_words[w] !== exp_words[w]) begin
          $display("Fail at %0t: %s word %0d read %h, expected %h",
                   $time, test_name, w, got_words[w], exp_words[w]);
          fails++;
        end
        for (int k = 0; k < `SIB_COEFF_PER_WORD; k++) begin
          code = got_words[w][2*k +: 2];
          idx  = `SIB_COEFF_PER_WORD * w + k;
          if (code != 2'b00) begin
            nonzero++;
          end
          if (check_weight && code == 2'b10) begin
            $display("Fail at %0t: %s coefficient %0d is not 0, +1 or -1",
                     $time, test_name, idx);
            fails++;
          end
          if (check_weight && code != 2'b00 && idx < `SIB_NUM_COEFF - `SIB_TAU && !picked[idx]) begin
            $display("Fail at %0t: %s coefficient %0d is nonzero but never chosen",
                     $time, test_name, idx);
            fails++;
          end
        end
      end
      if (check_weight && nonzero != `SIB_TAU) begin
        $display("Fail at %0t: %s has %0d nonzero coefficients", $time, test_name, nonzero);
        fails++;
      end
      tests_run++;
      errors += fails;
      if (fails != 0) begin
        tests_failed++;
      end
      $display("%s: %s", test_name, (fails == 0) ? "ok" : "mismatch");
      check_ack = 1'b1;
    end
  end

  initial begin
    rst_b        = 1'b0;
    zeroize_i    = 1'b0;
    data_valid_i = 1'b0;
    data_i       = '0;
    rd_addr_i    = '0;
    check_req    = 1'b0;
    check_ack    = 1'b0;
    lfsr_q       = 32'h44b8;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;

    for (int t = 0; t < 5; t++) begin
      make_random_stream();
      sample_in_ball_model(stream_q, exp_words, picked);
      run_test($sformatf("random stream %0d", t), 1'b1, 1'b0);
    end
    // Last random stream again, now with gaps between beats
    run_test("back-pressure", 1'b1, 1'b1);

    make_rejection_stream();
    sample_in_ball_model(stream_q, exp_words, picked);
    run_test("forced rejection", 1'b1, 1'b0);
    stream_q = alt_q;
    run_test("rejected bytes removed", 1'b1, 1'b0);

    make_collision_stream();
    sample_in_ball_model(stream_q, exp_words, picked);
    run_test("colliding indices", 1'b1, 1'b0);

    // At most 32 swaps in 10 beats, so the run is cut short
    make_random_stream();
    pulse_zeroize();
    send_stream(10, 1'b0);
    pulse_zeroize();
    read_back();
    exp_words = '{default: '0};
    request_check("zeroize mid-run", 1'b0);
    sample_in_ball_model(stream_q, exp_words, picked);
    run_test("run after zeroize", 1'b0, 1'b0);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && tests_run == NUM_TESTS) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
